// ==== rtl/alu_share_pkg.sv ====
`default_nettype none

package alu_share_pkg;

    localparam int num_ports  = 4;                  // Requesters sharing the unit.
    localparam int port_idx_w = $clog2(num_ports);  // Width of a requester tag.
    localparam int word_w     = 16;                 // Command word and result width.

    // Field widths of the two command-word forms.
    localparam int op_w      = 3;
    localparam int operand_w = 6;
    localparam int shift_w   = 3;
    localparam int value_w   = 12;

    // Register-form operations. Min and max compare unsigned.
    typedef enum logic [op_w-1:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_min = 3'd5,
        op_max = 3'd6,
        op_mul = 3'd7   // 6 by 6 unsigned product.
    } alu_op_e;

    // The top bit of a command word selects its form.
    typedef enum logic {
        reg_form = 1'b0,
        imm_form = 1'b1
    } op_kind_e;

    typedef struct packed {
        op_kind_e               form;  // Always reg_form in this view.
        alu_op_e                op;
        logic [operand_w-1:0]   a;
        logic [operand_w-1:0]   b;
    } reg_view_t;

    typedef struct packed {
        op_kind_e               form;  // Always imm_form in this view.
        logic [shift_w-1:0]     shift;
        logic [value_w-1:0]     value;
    } imm_view_t;

    // One 16-bit word read through whichever view its form bit selects.
    typedef union packed {
        reg_view_t reg_view;
        imm_view_t imm_view;
    } cmd_word_u;

endpackage

`default_nettype wire

// ==== rtl/alu_share_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decoded operation travelling from the decode stage to the execute stage.
interface op_bus_if;
    logic                                         valid;
    logic                                         ready;
    logic [alu_share_pkg::port_idx_w-1:0]         port;   // Requester tag.
    alu_share_pkg::op_kind_e                      kind;
    alu_share_pkg::alu_op_e                       op;
    logic [alu_share_pkg::operand_w-1:0]          a;
    logic [alu_share_pkg::operand_w-1:0]          b;
    logic [alu_share_pkg::shift_w-1:0]            shift;
    logic [alu_share_pkg::value_w-1:0]            value;

    modport source (output valid, port, kind, op, a, b, shift, value, input ready);
    modport sink   (input valid, port, kind, op, a, b, shift, value, output ready);
endinterface

// Tagged result travelling from the execute stage to the response stage.
interface res_bus_if;
    logic                                 valid;
    logic                                 ready;
    logic [alu_share_pkg::port_idx_w-1:0] port;
    logic [alu_share_pkg::word_w-1:0]     data;

    modport source (output valid, port, data, input ready);
    modport sink   (input valid, port, data, output ready);
endinterface

`default_nettype wire

// ==== rtl/priority_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

// Lowest set bit wins. The search is a binary tree of pairwise picks.
module priority_encoder import alu_share_pkg::*; #(
    parameter int PORTS = num_ports
) (
    input  logic [PORTS-1:0]         request,
    output logic                     found,
    output logic [$clog2(PORTS)-1:0] index,
    output logic [PORTS-1:0]         onehot
);
    localparam int idx_w = $clog2(PORTS);
    localparam int pad_w = 1 << idx_w;  // Request vector rounded up to a power of two.

    logic [pad_w-1:0] req_pad;
    logic             node_found [idx_w+1][pad_w];
    logic [idx_w-1:0] node_index [idx_w+1][pad_w];

    assign req_pad = pad_w'(request);  // Padding bits are zero and never win.

    // Leaves are the request bits themselves, each with a local index of zero.
    for (genvar n = 0; n < pad_w; n++) begin : g_leaf
        assign node_found[0][n] = req_pad[n];
        assign node_index[0][n] = '0;
    end

    // Each node prefers its lower child and sets bit l-1 when the upper child wins.
    for (genvar l = 1; l <= idx_w; l++) begin : g_level
        for (genvar n = 0; n < (pad_w >> l); n++) begin : g_node
            assign node_found[l][n] = node_found[l-1][2*n] | node_found[l-1][2*n+1];
            assign node_index[l][n] = node_found[l-1][2*n] ? node_index[l-1][2*n]
                                    : node_index[l-1][2*n+1] | idx_w'(1 << (l-1));
        end
    end

    assign found  = node_found[idx_w][0];                   // The root covers every bit.
    assign index  = node_index[idx_w][0];
    assign onehot = found ? (PORTS'(1) << index) : '0;

endmodule

`default_nettype wire

// ==== rtl/arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

// Round-robin arbiter. A grant is held until the granted requester is acknowledged,
// then priority rotates to the requesters above the one just served.
module arbiter import alu_share_pkg::*; #(
    parameter int PORTS = num_ports
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [PORTS-1:0]         request,
    input  logic [PORTS-1:0]         acknowledge,
    output logic [PORTS-1:0]         grant,
    output logic                     grant_valid,
    output logic [$clog2(PORTS)-1:0] grant_index
);
    localparam int idx_w = $clog2(PORTS);

    logic [PORTS-1:0] grant_reg, grant_next;
    logic             grant_valid_reg, grant_valid_next;
    logic [idx_w-1:0] grant_index_reg, grant_index_next;
    logic [PORTS-1:0] mask_reg, mask_next;  // Set bits lie above the last winner.

    logic             raw_found;
    logic [idx_w-1:0] raw_index;
    logic [PORTS-1:0] raw_onehot;
    logic             masked_found;
    logic [idx_w-1:0] masked_index;
    logic [PORTS-1:0] masked_onehot;

    // Search over every request.
    priority_encoder #(.PORTS(PORTS)) u_raw_enc (
        .request (request),
        .found   (raw_found),
        .index   (raw_index),
        .onehot  (raw_onehot)
    );

    // Search restricted to the requesters after the last winner.
    priority_encoder #(.PORTS(PORTS)) u_masked_enc (
        .request (request & mask_reg),
        .found   (masked_found),
        .index   (masked_index),
        .onehot  (masked_onehot)
    );

    always_comb begin
        grant_next       = grant_reg;        // By default the current grant stands.
        grant_valid_next = grant_valid_reg;
        grant_index_next = grant_index_reg;
        mask_next        = mask_reg;

        if (grant_valid_reg && |(grant_reg & request) && !(|(grant_reg & acknowledge))) begin
            // Still waiting for the granted requester to be served.
            // A grant left on a requester with no word pending is passed on.
        end else if (masked_found) begin
            grant_next       = masked_onehot;  // Next requester in rotation.
            grant_valid_next = 1'b1;
            grant_index_next = masked_index;
            mask_next        = {PORTS{1'b1}} << (masked_index + 1);
        end else if (raw_found) begin
            // Nobody above the last winner, so wrap to the lowest index.
            grant_next       = raw_onehot;
            grant_valid_next = 1'b1;
            grant_index_next = raw_index;
            mask_next        = {PORTS{1'b1}} << (raw_index + 1);
        end else begin
            grant_next       = '0;  // Idle with no requests pending.
            grant_valid_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_reg       <= '0;
            grant_valid_reg <= 1'b0;
            grant_index_reg <= '0;
            mask_reg        <= '0;  // First search after reset starts at index 0.
        end else begin
            grant_reg       <= grant_next;
            grant_valid_reg <= grant_valid_next;
            grant_index_reg <= grant_index_next;
            mask_reg        <= mask_next;
        end
    end

    assign grant       = grant_reg;
    assign grant_valid = grant_valid_reg;
    assign grant_index = grant_index_reg;

endmodule

`default_nettype wire

// ==== rtl/op_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

// Issue and decode stage. One requester is granted at a time and its word is
// unpacked into the decoded operation register.
module op_decode import alu_share_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [num_ports-1:0]        req_valid,
    output logic [num_ports-1:0]        req_ready,
    input  logic [num_ports*word_w-1:0] req_data,
    op_bus_if.source                    op_out
);
    logic [num_ports-1:0]  grant;
    logic                  grant_valid;
    logic [port_idx_w-1:0] grant_index;
    logic [num_ports-1:0]  ack;     // Transfer on the granted port.
    logic                  space;   // The decode register can take a word this cycle.
    logic                  take;
    cmd_word_u             cmd;

    // Request valids drive the arbiter and completed transfers release the grant.
    arbiter #(.PORTS(num_ports)) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (req_valid),
        .acknowledge (ack),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    assign space     = !op_out.valid || op_out.ready;
    assign req_ready = (grant_valid && space) ? grant : '0;  // Only the granted port.
    assign ack       = req_valid & req_ready;
    assign take      = |ack;

    assign cmd = req_data[grant_index*word_w +: word_w];  // Word of the granted requester.

    always_ff @(posedge clk) begin
        if (rst) begin
            op_out.valid <= 1'b0;
        end else if (space) begin
            op_out.valid <= take;  // Drains or refills in the same cycle.
        end
    end

    // Both views are captured. The execute stage reads the ones its kind selects.
    always_ff @(posedge clk) begin
        if (take) begin
            op_out.port  <= grant_index;
            op_out.kind  <= cmd.reg_view.form;
            op_out.op    <= cmd.reg_view.op;
            op_out.a     <= cmd.reg_view.a;
            op_out.b     <= cmd.reg_view.b;
            op_out.shift <= cmd.imm_view.shift;
            op_out.value <= cmd.imm_view.value;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/op_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

// Execute stage. Operands are zero-extended to the result width and all
// arithmetic wraps modulo 2**word_w.
module op_execute import alu_share_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    op_bus_if.sink    op_in,
    res_bus_if.source res_out
);
    logic              space;
    logic              take;
    logic [word_w-1:0] ext_a;
    logic [word_w-1:0] ext_b;
    logic [word_w-1:0] reg_result;
    logic [word_w-1:0] imm_result;
    logic [word_w-1:0] result;

    assign space       = !res_out.valid || res_out.ready;  // Output empty or draining.
    assign op_in.ready = space;
    assign take        = op_in.valid && space;

    assign ext_a = word_w'(op_in.a);
    assign ext_b = word_w'(op_in.b);

    always_comb begin
        unique case (op_in.op)
            op_add:  reg_result = ext_a + ext_b;
            op_sub:  reg_result = ext_a - ext_b;  // Negative results wrap.
            op_and:  reg_result = ext_a & ext_b;
            op_or:   reg_result = ext_a | ext_b;
            op_xor:  reg_result = ext_a ^ ext_b;
            op_min:  reg_result = (ext_a < ext_b) ? ext_a : ext_b;
            op_max:  reg_result = (ext_a > ext_b) ? ext_a : ext_b;
            op_mul:  reg_result = ext_a * ext_b;  // At most 12 bits wide.
            default: reg_result = '0;
        endcase
    end

    // The shift happens at full width, so bits pushed past bit 15 are lost.
    assign imm_result = word_w'(op_in.value) << op_in.shift;

    assign result = (op_in.kind == imm_form) ? imm_result : reg_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_out.valid <= 1'b0;
        end else if (space) begin
            res_out.valid <= op_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_out.port <= op_in.port;  // Tag follows the result.
            res_out.data <= result;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/result_route.sv ====
`timescale 1ns/10ps
`default_nettype none

// Response stage built as a two-entry skid buffer. The output entry feeds the
// response stream and the skid entry catches a result arriving during a stall.
module result_route import alu_share_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    res_bus_if.sink               res_in,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic [port_idx_w-1:0] rsp_port,
    output logic [word_w-1:0]     rsp_data
);
    logic                  skid_valid;
    logic [port_idx_w-1:0] skid_port;
    logic [word_w-1:0]     skid_data;
    logic                  push;
    logic                  load_out;  // The output entry is free or drains this cycle.

    assign res_in.ready = !skid_valid;  // A skid entry is only used when the output is full.
    assign push         = res_in.valid && res_in.ready;
    assign load_out     = !rsp_valid || rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_out) begin
            rsp_valid  <= skid_valid || push;  // Older skid entry goes first.
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            rsp_port <= skid_valid ? skid_port : res_in.port;
            rsp_data <= skid_valid ? skid_data : res_in.data;
        end
        if (push && !load_out) begin
            skid_port <= res_in.port;  // Parked until the output drains.
            skid_data <= res_in.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu_share.sv ====
`timescale 1ns/10ps
`default_nettype none

// Shared arithmetic unit for four requesters. Words flow through decode,
// execute and response stages, each holding one registered item, with the
// response stage able to hold a second one under back-pressure.
module alu_share import alu_share_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,

    // Requester side. Word i sits in bits 16i to 16i+15 of req_data.
    input  logic [num_ports-1:0]        req_valid,
    output logic [num_ports-1:0]        req_ready,
    input  logic [num_ports*word_w-1:0] req_data,

    // Response stream tagged with the requester index.
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [port_idx_w-1:0]       rsp_port,
    output logic [word_w-1:0]           rsp_data
);

    op_bus_if  op_bus ();   // Decode to execute.
    res_bus_if res_bus ();  // Execute to response.

    // Arbitration and decode. A word accepted at edge E is on op_bus after E.
    op_decode u_op_decode (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_data  (req_data),
        .op_out    (op_bus.source)
    );

    // Computes the result one edge later.
    op_execute u_op_execute (
        .clk     (clk),
        .rst     (rst),
        .op_in   (op_bus.sink),
        .res_out (res_bus.source)
    );

    // Presents the result on the response stream one more edge later.
    result_route u_result_route (
        .clk       (clk),
        .rst       (rst),
        .res_in    (res_bus.sink),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_port  (rsp_port),
        .rsp_data  (rsp_data)
    );

endmodule

`default_nettype wire

// ==== verification/alu_share_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

// Stream protocol and reset checks for the shared unit.
module alu_share_sva import alu_share_pkg::*; (
    input logic                        clk,
    input logic                        rst,
    input logic [num_ports-1:0]        req_valid,
    input logic [num_ports-1:0]        req_ready,
    input logic [num_ports*word_w-1:0] req_data,
    input logic                        rsp_valid,
    input logic                        rsp_ready,
    input logic [port_idx_w-1:0]       rsp_port,
    input logic [word_w-1:0]           rsp_data,
    input logic                        op_valid,   // Decode to execute valid.
    input logic                        res_valid   // Execute to response valid.
);
    int unsigned failures = 0;  // Summed into the testbench result.

    ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(req_ready))
        else begin
            $error("req_ready has more than one bit set");
            failures++;
        end

    // A stalled request word must stay offered and unchanged.
    for (genvar i = 0; i < num_ports; i++) begin : g_req
        req_stable: assert property (@(posedge clk) disable iff (rst)
            req_valid[i] && !req_ready[i] |=> req_valid[i] && $stable(req_data[i*word_w +: word_w]))
            else begin
                $error("request word changed or was withdrawn while stalled");
                failures++;
            end
    end

    rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable({rsp_port, rsp_data}))
        else begin
            $error("response changed or was withdrawn while stalled");
            failures++;
        end

    // One reset edge clears every control output.
    reset_idle: assert property (@(posedge clk)
        rst |=> req_ready == '0 && !rsp_valid && !op_valid && !res_valid)
        else begin
            $error("control outputs active after a reset edge");
            failures++;
        end

endmodule

bind alu_share alu_share_sva u_sva (.*, .op_valid(op_bus.valid), .res_valid(res_bus.valid));

`default_nettype wire

// ==== verification/alu_share_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_share_tb import alu_share_pkg::*; ();
    localparam int     clk_period      = 100;  // In ns.
    localparam int     reset_cycles    = 8;
    localparam int     total_words     = 192;  // All words issued over the whole run.
    localparam int     cycles_per_word = 16;   // Loose bound that covers random stalls.
    localparam longint watchdog_ns     =
        longint'(reset_cycles + total_words * cycles_per_word) * clk_period;

    logic                        clk;
    logic                        rst;
    logic [num_ports-1:0]        req_valid;
    logic [num_ports-1:0]        req_ready;
    logic [num_ports*word_w-1:0] req_data;
    logic                        rsp_valid;
    logic                        rsp_ready;
    logic [port_idx_w-1:0]       rsp_port;
    logic [word_w-1:0]           rsp_data;

    logic [31:0]          rng_state = 32'h89fa8f90;
    logic [word_w-1:0]    send_q [num_ports][$];  // The front word is the one on the bus.
    logic [word_w-1:0]    exp_q  [num_ports][$];  // Expected results in issue order.
    logic [word_w-1:0]    expected;
    logic [num_ports-1:0] accepted;               // Front word taken at the last edge.
    int                   outstanding;            // Words queued but not yet answered.
    int                   value_errors;
    int                   other_errors;
    int                   prev_port;
    longint               edge_count;
    longint               xfer_edge;              // Edge of the latest request transfer.
    bit                   stall_mode;
    bit                   check_order;
    bit                   check_latency;
    bit                   order_started;
    bit                   rsp_seen;               // The rsp_valid seen at the last edge.

    alu_share dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Xorshift32 step.
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Reference result, worked out from the command-word layout.
    function automatic logic [word_w-1:0] expected_result(input logic [word_w-1:0] w);
        logic [word_w-1:0] a;
        logic [word_w-1:0] b;
        logic [31:0]       wide;
        a    = word_w'(w[11:6]);
        b    = word_w'(w[5:0]);
        wide = 32'(w[11:0]) << w[14:12];
        if (w[15]) begin
            return wide[word_w-1:0];  // Immediate form keeps only the low 16 bits.
        end
        case (alu_op_e'(w[14:12]))
            op_add:  return a + b;
            op_sub:  return a - b;    // Wraps below zero.
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_min:  return (a < b) ? a : b;
            op_max:  return (a > b) ? a : b;
            default: return a * b;
        endcase
    endfunction

    task automatic queue_word(input int port, input logic [word_w-1:0] w);
        send_q[port].push_back(w);
        outstanding++;
    endtask

    // Returns on the first falling edge with every queued word answered.
    task automatic wait_idle();
        do @(negedge clk); while (outstanding != 0);
    endtask

    task automatic print_counts();
        $display("%0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, dut.u_sva.failures);
    endtask

    // Request side. A word stays on the bus until the edge that takes it.
    always @(negedge clk) begin
        for (int p = 0; p < num_ports; p++) begin
            if (accepted[p]) begin
                send_q[p].delete(0);
                accepted[p] = 1'b0;
            end
            if (!rst && send_q[p].size() > 0) begin
                req_valid[p]                 <= 1'b1;
                req_data[p*word_w +: word_w] <= send_q[p][0];
            end else begin
                req_valid[p] <= 1'b0;
            end
        end
        rsp_ready <= stall_mode ? 1'(next_random()) : 1'b1;  // Random back-pressure.
    end

    // Monitor. Request transfers push expectations and response transfers pop them.
    always @(posedge clk) begin
        edge_count++;
        if (rst) begin
            for (int p = 0; p < num_ports; p++) begin
                send_q[p].delete();   // Reset drops everything in flight.
                exp_q[p].delete();
            end
            accepted    = '0;
            outstanding = 0;
            rsp_seen    = 1'b0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (req_valid[p] && req_ready[p]) begin
                    exp_q[p].push_back(expected_result(req_data[p*word_w +: word_w]));
                    accepted[p] = 1'b1;
                    xfer_edge   = edge_count;
                    if (check_order && order_started) begin
                        assert (p == (prev_port + 1) % num_ports) else begin
                            $display("error: req_ready granted 0x%h, expected 0x%h",
                                     p, (prev_port + 1) % num_ports);
                            value_errors++;
                        end
                    end
                    order_started = 1'b1;
                    prev_port     = p;
                end
            end
            // A rise seen now happened at the previous edge.
            if (check_latency && rsp_valid && !rsp_seen) begin
                assert (edge_count - 1 - xfer_edge == 2) else begin
                    $display("error: rsp_valid rose 0x%h edges after the transfer, expected 0x2",
                             edge_count - 1 - xfer_edge);
                    value_errors++;
                end
            end
            rsp_seen = rsp_valid;
            if (rsp_valid && rsp_ready) begin
                assert (exp_q[rsp_port].size() > 0) else begin
                    $display("response for requester %0d arrived with no request outstanding",
                             rsp_port);
                    other_errors++;
                end
                if (exp_q[rsp_port].size() > 0) begin
                    expected = exp_q[rsp_port].pop_front();
                    outstanding--;
                    assert (rsp_data == expected) else begin
                        $display("error: rsp_data 0x%h on port 0x%h, expected 0x%h",
                                 rsp_data, rsp_port, expected);
                        value_errors++;
                    end
                end
            end
        end
    end

    initial begin
        rst       = 1'b1;
        req_valid = '0;
        req_data  = '0;
        rsp_ready = 1'b1;
        accepted  = '0;
        {outstanding, value_errors, other_errors, prev_port} = '0;
        {edge_count, xfer_edge} = '0;
        {stall_mode, check_order, check_latency, order_started, rsp_seen} = '0;
        repeat (reset_cycles) @(negedge clk);
        rst <= 1'b0;
        // Every register-form operation four times on requester 1, immediates on 3.
        @(posedge clk);
        for (int i = 0; i < 32; i++) begin
            queue_word(1, {1'b0, 3'(i), 12'(next_random())});
        end
        queue_word(3, {1'b1, 3'd7, 12'hfff});  // Top bits are shifted out.
        for (int i = 0; i < 15; i++) begin
            queue_word(3, {1'b1, 3'(next_random()), 12'(next_random())});
        end
        wait_idle();
        // All four requesters valid at once, so grants rotate.
        @(posedge clk);
        check_order   = 1'b1;
        order_started = 1'b0;
        for (int i = 0; i < 32; i++) begin
            queue_word(i % num_ports, 16'(next_random()));
        end
        wait_idle();
        @(posedge clk);
        check_order = 1'b0;
        stall_mode  = 1'b1;
        for (int i = 0; i < 64; i++) begin
            queue_word(i % num_ports, 16'(next_random()));
        end
        wait_idle();
        // One word at a time on requester 2 with rsp_ready held high.
        @(posedge clk);
        stall_mode    = 1'b0;
        check_latency = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            queue_word(2, 16'(next_random()));
            wait_idle();
        end
        @(posedge clk);
        check_latency = 1'b0;
        stall_mode    = 1'b1;
        for (int i = 0; i < 24; i++) begin
            queue_word(i % num_ports, 16'(next_random()));
        end
        repeat (6) @(negedge clk);
        rst <= 1'b1;                             // Reset in the middle of traffic.
        @(negedge clk);
        assert (req_ready == '0 && !rsp_valid) else begin
            $display("error: req_ready 0x%h rsp_valid 0x%h in reset, expected 0x0 0x0",
                     req_ready, rsp_valid);
            value_errors++;
        end
        repeat (2) @(negedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < 16; i++) begin
            queue_word(i % num_ports, 16'(next_random()));
        end
        wait_idle();
        print_counts();
        if (value_errors == 0 && other_errors == 0 && dut.u_sva.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: some queued words were never answered");
        print_counts();
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_share.f ====
rtl/alu_share_pkg.sv
rtl/alu_share_if.sv
rtl/priority_encoder.sv
rtl/arbiter.sv
rtl/op_decode.sv
rtl/op_execute.sv
rtl/result_route.sv
rtl/alu_share.sv
verification/alu_share_sva.sv
verification/alu_share_tb.sv

// ==== Bender.yml ====
package:
  name: alu_share

sources:
  - rtl/alu_share_pkg.sv
  - rtl/alu_share_if.sv
  - rtl/priority_encoder.sv
  - rtl/arbiter.sv
  - rtl/op_decode.sv
  - rtl/op_execute.sv
  - rtl/result_route.sv
  - rtl/alu_share.sv
  - target: test
    files:
      - verification/alu_share_sva.sv
      - verification/alu_share_tb.sv
